/* lsu.f */
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_ctrl.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
testbench/axi_lite_mem.sv
testbench/lsu_chk.sv
testbench/tb_lsu.sv

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it.
# The run counts as passing only if the pass line appears in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lsu -f lsu.f -o tb_lsu \
    && ./obj_dir/tb_lsu | tee /dev/stderr | grep -qx "Test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* testbench/tb_lsu.sv */
// Load/store unit testbench with clock, reset, register file, stimulus,
// reference model, compare process and timeout
`default_nettype none

module tb_lsu;

    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    // Stores, loads, negative offsets, random mix, non-memory op, reset
    localparam int N_RANDOM    = 40;
    localparam int NUM_OPS     = 7 + 13 + 2 + N_RANDOM + 1 + 1;
    localparam int CYCLE_LIMIT = NUM_OPS * 40;

    logic        aclk = 1'b0;
    logic        aresetn = 1'b0;
    logic        en = 1'b0;
    logic        ready;
    word_t       instr = '0;
    reg_idx_t    rs1_addr;
    reg_idx_t    rs2_addr;
    word_t       rs1_val;
    word_t       rs2_val;
    logic        rd_wr;
    reg_idx_t    rd_addr;
    word_t       rd_val;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    word_t       wdata;
    strb_t       wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    word_t       rdata;
    logic [1:0]  rresp;

    // Register file and shadow of the memory image
    word_t       regs [32];
    word_t       shadow [8];
    // Expected register writes, in load order
    reg_idx_t    exp_rd_q [$];
    word_t       exp_val_q [$];
    reg_idx_t    next_rd;
    word_t       next_val;
    // Full addresses taken on the AW and AR handshakes
    logic [31:0] seen_awaddr;
    logic [31:0] seen_araddr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          seed = 24327;

    always #10 aclk = ~aclk;

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    lsu_top #(
        .ADDR_W (32)
    ) dut (
        .aclk (aclk), .aresetn (aresetn), .en (en), .ready (ready), .instr (instr),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_val (rs1_val), .rs2_val (rs2_val),
        .rd_wr (rd_wr), .rd_addr (rd_addr), .rd_val (rd_val),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    axi_lite_mem u_mem (
        .aclk (aclk), .aresetn (aresetn),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and checking
    //////////////////////////////////////////////////////////////////////

    // Load result, or memory word after a store, from the access rules
    function automatic word_t reference_result(logic is_st, word_t mem_word, word_t data,
                                               funct3_t f3, byte_off_t off);
        int    nbytes;
        word_t mask;
        word_t lane;
        word_t result;
        // B, H, W give 1, 2, 4 bytes
        nbytes = 1 << f3[1:0];
        mask   = (nbytes == 4) ? 32'hffff_ffff : (32'd1 << (8 * nbytes)) - 32'd1;
        if (is_st) begin
            result = mem_word;
            for (int b = 0; b < nbytes; b++) begin
                result[8*(off+b) +: 8] = data[8*b +: 8];
            end
        end else begin
            lane   = mem_word >> (8 * off);
            result = lane & mask;
            // Signed forms copy the top bit of the accessed field upward
            if (!f3[2] && lane[8*nbytes-1]) begin
                result = result | ~mask;
            end
        end
        return result;
    endfunction

    task automatic compare_value(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Every rd write must match the oldest outstanding load
    always @(posedge aclk) begin
        if (aresetn && rd_wr) begin
            if (exp_val_q.size() == 0) begin
                errors++;
                $display("Register write to x%0d with no load outstanding", rd_addr);
            end else begin
                next_rd  = exp_rd_q.pop_front();
                next_val = exp_val_q.pop_front();
                compare_value("rd_addr", word_t'(rd_addr), word_t'(next_rd));
                compare_value("rd_val", rd_val, next_val);
            end
        end
    end

    // The memory model decodes only a few address bits, so keep the full ones
    always @(posedge aclk) begin
        if (awvalid && awready) begin
            seen_awaddr <= awaddr;
        end
        if (arvalid && arready) begin
            seen_araddr <= araddr;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    // Waits for ready, holds en for one accepting edge, waits for the end
    task automatic issue_and_wait(word_t ins);
        while (!ready) begin
            @(posedge aclk);
            #1;
        end
        en    = 1'b1;
        instr = ins;
        @(posedge aclk);
        #1;
        en    = 1'b0;
        instr = '0;
        while (!ready) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // One load or store, predicted from the shadow memory
    task automatic mem_access(logic is_st, funct3_t f3, reg_idx_t rs1, reg_idx_t rx,
                              logic [11:0] imm);
        word_t ins;
        word_t ea;
        int    idx;
        ea  = regs[rs1] + {{20{imm[11]}}, imm};
        idx = int'(ea[4:2]);
        if (is_st) begin
            ins = {imm[11:5], rx, rs1, f3, imm[4:0], OPCODE_STORE};
            shadow[idx] = reference_result(1'b1, shadow[idx], regs[rx], f3, ea[1:0]);
        end else begin
            ins = {imm, rs1, f3, rx, OPCODE_LOAD};
            exp_rd_q.push_back(rx);
            exp_val_q.push_back(reference_result(1'b0, shadow[idx], '0, f3, ea[1:0]));
        end
        issue_and_wait(ins);
        if (is_st) begin
            compare_value("awaddr", seen_awaddr, ea);
            compare_value("mem", u_mem.mem[idx], shadow[idx]);
        end else begin
            compare_value("araddr", seen_araddr, ea);
            if (exp_val_q.size() != 0) begin
                errors++;
                $display("Load into x%0d ended without a register write", rx);
                exp_rd_q.delete();
                exp_val_q.delete();
            end
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        funct3_t     f3;
        byte_off_t   off;
        logic        is_st;
        int          e0;

        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            shadow[i] = 32'h80c0_40a0 + 32'(i) * 32'h1357_9bdf;
        end
        // Base pointers and store data
        regs[1] = 32'h0000_0100;
        regs[2] = 32'h0000_0120;
        regs[5] = 32'hc3a5_7e19;
        regs[6] = 32'h5a5a_8421;

        // Reset
        e0 = errors;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        compare_value("ready", word_t'(ready), 32'd0);
        while (!ready) begin
            @(posedge aclk);
            #1;
        end
        compare_value("awvalid", word_t'(awvalid), 32'd0);
        compare_value("wvalid", word_t'(wvalid), 32'd0);
        compare_value("arvalid", word_t'(arvalid), 32'd0);
        compare_value("bready", word_t'(bready), 32'd0);
        compare_value("rready", word_t'(rready), 32'd0);
        compare_value("rd_wr", word_t'(rd_wr), 32'd0);
        finish_test("reset", e0);

        // Stores: every byte lane, both halves, a full word
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            mem_access(1'b1, F3_B, 5'd1, 5'd5, 12'(4 + k));
        end
        mem_access(1'b1, F3_H, 5'd1, 5'd5, 12'd8);
        mem_access(1'b1, F3_H, 5'd1, 5'd6, 12'd10);
        mem_access(1'b1, F3_W, 5'd1, 5'd6, 12'd12);
        finish_test("stores", e0);

        // Loads from untouched words, bytes of both signs
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            mem_access(1'b0, F3_B, 5'd1, reg_idx_t'(10 + k), 12'(16 + k));
            mem_access(1'b0, F3_BU, 5'd1, reg_idx_t'(14 + k), 12'(16 + k));
        end
        for (int k = 0; k < 2; k++) begin
            mem_access(1'b0, F3_H, 5'd1, reg_idx_t'(18 + k), 12'(20 + 2 * k));
            mem_access(1'b0, F3_HU, 5'd1, reg_idx_t'(20 + k), 12'(20 + 2 * k));
        end
        mem_access(1'b0, F3_W, 5'd1, 5'd22, 12'd24);
        finish_test("loads", e0);

        // Negative offsets from x2 land in word 1
        e0 = errors;
        mem_access(1'b1, F3_H, 5'd2, 5'd6, 12'hfe6);
        mem_access(1'b0, F3_W, 5'd2, 5'd23, 12'hfe4);
        finish_test("negative_imm", e0);

        // Random mix of sizes, offsets and directions
        e0 = errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            r     = $random(seed);
            is_st = r[3];
            case (r[5:4])
                2'd0: begin
                    f3  = (r[6] && !is_st) ? F3_BU : F3_B;
                    off = r[8:7];
                end
                2'd1: begin
                    f3  = (r[6] && !is_st) ? F3_HU : F3_H;
                    off = {r[7], 1'b0};
                end
                default: begin
                    f3  = F3_W;
                    off = 2'd0;
                end
            endcase
            if (is_st) begin
                regs[5] = $random(seed);
                mem_access(1'b1, f3, 5'd1, 5'd5, {7'd0, r[2:0], off});
            end else begin
                mem_access(1'b0, f3, 5'd1, reg_idx_t'(10 + r[11:9]), {7'd0, r[2:0], off});
            end
        end
        finish_test("random", e0);

        // ADDI held on the issue port must not start a bus access
        e0 = errors;
        en    = 1'b1;
        instr = 32'h0010_8093;
        repeat (3) begin
            @(posedge aclk);
            #1;
            compare_value("awvalid", word_t'(awvalid), 32'd0);
            compare_value("wvalid", word_t'(wvalid), 32'd0);
            compare_value("arvalid", word_t'(arvalid), 32'd0);
            compare_value("ready", word_t'(ready), 32'd1);
        end
        en    = 1'b0;
        instr = '0;
        finish_test("non_memory", e0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/lsu_chk.sv */
// Concurrent AXI4-lite stability and register write checks
`default_nettype none

module lsu_chk #(
    parameter int ADDR_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              ready,
    input  logic              rd_wr,
    input  logic              awvalid,
    input  logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    input  logic              wready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              arvalid,
    input  logic              arready,
    input  logic [ADDR_W-1:0] araddr
);

    timeunit 1ns;
    timeprecision 100ps;

    // AW held with its address until taken
    assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed under stall");

    // W held with data and strobes until taken
    assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("W valid or payload changed under stall");

    assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid or address changed under stall");

    // Register write only inside a busy access
    assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> !ready)
        else $error("Register write while ready is high");

    assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid |-> wstrb != 4'b0000)
        else $error("Write data with no strobe set");

endmodule

bind lsu_top lsu_chk #(
    .ADDR_W  (ADDR_W)
) u_chk (
    .aclk    (aclk),
    .aresetn (aresetn),
    .ready   (ready),
    .rd_wr   (rd_wr),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr)
);

`default_nettype wire

/* testbench/axi_lite_mem.sv */
// AXI4-lite slave memory model, 8 words
// Random stalls on every channel from a seeded generator
`default_nettype none

module axi_lite_mem (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [8];
    int          seed = 24327;
    // One random bit per channel each cycle
    logic [31:0] roll;
    logic        aw_got;
    logic        w_got;
    logic        b_pend;
    logic        r_pend;
    logic [2:0]  aw_idx;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;

    // Always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            // Fill pattern, a function of the word index
            for (int i = 0; i < 8; i++) begin
                mem[i] <= 32'h80c0_40a0 + 32'(i) * 32'h1357_9bdf;
            end
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_pend  <= 1'b0;
            r_pend  <= 1'b0;
        end else begin
            roll = $random(seed);

            ////////////////////////////////////////////////////////////////////
            // Write path
            ////////////////////////////////////////////////////////////////////

            // AW taken once per write
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                aw_idx  <= awaddr[4:2];
            end else if (awvalid && !aw_got && roll[0]) begin
                awready <= 1'b1;
            end
            // W taken independently of AW
            if (wvalid && wready) begin
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end else if (wvalid && !w_got && roll[1]) begin
                wready <= 1'b1;
            end
            // Both halves in, update the enabled bytes
            if (aw_got && w_got) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb_q[b]) begin
                        mem[aw_idx][8*b +: 8] <= w_data_q[8*b +: 8];
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
            end
            // Response after a random delay
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && roll[2]) begin
                bvalid <= 1'b1;
                b_pend <= 1'b0;
            end

            ////////////////////////////////////////////////////////////////////
            // Read path
            ////////////////////////////////////////////////////////////////////

            if (arvalid && arready) begin
                arready <= 1'b0;
                r_pend  <= 1'b1;
                rdata   <= mem[araddr[4:2]];
            end else if (arvalid && !r_pend && !rvalid && roll[3]) begin
                arready <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pend && roll[4]) begin
                rvalid <= 1'b1;
                r_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
// Load/store unit top level
// Connects decode, control and load alignment to core and AXI4-lite ports
`default_nettype none

module lsu_top #(
    parameter int ADDR_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    // Issue side
    input  logic              en,
    output logic              ready,
    input  lsu_pkg::word_t    instr,
    // Register file read ports
    output lsu_pkg::reg_idx_t rs1_addr,
    output lsu_pkg::reg_idx_t rs2_addr,
    input  lsu_pkg::word_t    rs1_val,
    input  lsu_pkg::word_t    rs2_val,
    // Register file write port
    output logic              rd_wr,
    output lsu_pkg::reg_idx_t rd_addr,
    output lsu_pkg::word_t    rd_val,
    // AXI4-lite write address
    output logic              awvalid,
    input  logic              awready,
    output logic [ADDR_W-1:0] awaddr,
    // AXI4-lite write data
    output logic              wvalid,
    input  logic              wready,
    output lsu_pkg::word_t    wdata,
    output lsu_pkg::strb_t    wstrb,
    // AXI4-lite write response, code ignored
    input  logic              bvalid,
    output logic              bready,
    input  logic [1:0]        bresp,
    // AXI4-lite read address
    output logic              arvalid,
    input  logic              arready,
    output logic [ADDR_W-1:0] araddr,
    // AXI4-lite read data, code ignored
    input  logic              rvalid,
    output logic              rready,
    input  lsu_pkg::word_t    rdata,
    input  logic [1:0]        rresp
);

    import lsu_pkg::*;

    // Decode to control
    logic              is_load;
    logic              is_store;
    logic [ADDR_W-1:0] addr;
    funct3_t           funct3;
    reg_idx_t          rd;
    word_t             store_data;
    strb_t             store_strb;

    // Control to load alignment
    logic              load_done;
    funct3_t           req_funct3;
    byte_off_t         req_offset;
    reg_idx_t          req_rd;

    //////////////////////////////////////////////////////////////////////
    // Issue path
    //////////////////////////////////////////////////////////////////////

    lsu_decode #(
        .ADDR_W     (ADDR_W)
    ) u_decode (
        .instr      (instr),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd         (rd),
        .funct3     (funct3),
        .is_load    (is_load),
        .is_store   (is_store),
        .addr       (addr),
        .store_data (store_data),
        .store_strb (store_strb)
    );

    //////////////////////////////////////////////////////////////////////
    // Bus control and load return
    //////////////////////////////////////////////////////////////////////

    lsu_ctrl #(
        .ADDR_W     (ADDR_W)
    ) u_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .en         (en),
        .ready      (ready),
        .is_load    (is_load),
        .is_store   (is_store),
        .addr       (addr),
        .funct3     (funct3),
        .rd         (rd),
        .store_data (store_data),
        .store_strb (store_strb),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .load_done  (load_done),
        .req_funct3 (req_funct3),
        .req_offset (req_offset),
        .req_rd     (req_rd)
    );

    // Load data straight from the R channel into rd
    lsu_load_align u_load_align (
        .rdata      (rdata),
        .load_done  (load_done),
        .req_funct3 (req_funct3),
        .req_offset (req_offset),
        .req_rd     (req_rd),
        .rd_wr      (rd_wr),
        .rd_addr    (rd_addr),
        .rd_val     (rd_val)
    );

endmodule

`default_nettype wire

/* rtl/lsu_load_align.sv */
// Load data alignment, sign or zero extension and rd write port
`default_nettype none

module lsu_load_align (
    input  lsu_pkg::word_t     rdata,
    input  logic               load_done,
    input  lsu_pkg::funct3_t   req_funct3,
    input  lsu_pkg::byte_off_t req_offset,
    input  lsu_pkg::reg_idx_t  req_rd,
    output logic               rd_wr,
    output lsu_pkg::reg_idx_t  rd_addr,
    output lsu_pkg::word_t     rd_val
);

    import lsu_pkg::*;

    word_t rot;

    // Bring the addressed byte down to lane 0
    always_comb begin
        case (req_offset)
            2'd1:    rot = {rdata[7:0], rdata[31:8]};
            2'd2:    rot = {rdata[15:0], rdata[31:16]};
            2'd3:    rot = {rdata[23:0], rdata[31:24]};
            default: rot = rdata;
        endcase
    end

    // Size select with sign or zero fill
    always_comb begin
        case (req_funct3)
            F3_B:    rd_val = {{24{rot[7]}}, rot[7:0]};
            F3_BU:   rd_val = {24'd0, rot[7:0]};
            F3_H:    rd_val = {{16{rot[15]}}, rot[15:0]};
            F3_HU:   rd_val = {16'd0, rot[15:0]};
            default: rd_val = rot;
        endcase
    end

    // Whole register written in the R handshake cycle
    assign rd_wr   = load_done;
    assign rd_addr = req_rd;

endmodule

`default_nettype wire

/* rtl/lsu_ctrl.sv */
// Request FSM, issue handshake and AXI4-lite channel control
// with the registered request context
`default_nettype none

module lsu_ctrl #(
    parameter int ADDR_W = 32
) (
    input  logic                aclk,
    input  logic                aresetn,
    // Issue side
    input  logic                en,
    output logic                ready,
    // Decoded request
    input  logic                is_load,
    input  logic                is_store,
    input  logic [ADDR_W-1:0]   addr,
    input  lsu_pkg::funct3_t    funct3,
    input  lsu_pkg::reg_idx_t   rd,
    input  lsu_pkg::word_t      store_data,
    input  lsu_pkg::strb_t      store_strb,
    // AXI4-lite write channels
    output logic                awvalid,
    input  logic                awready,
    output logic [ADDR_W-1:0]   awaddr,
    output logic                wvalid,
    input  logic                wready,
    output lsu_pkg::word_t      wdata,
    output lsu_pkg::strb_t      wstrb,
    input  logic                bvalid,
    output logic                bready,
    // AXI4-lite read channels
    output logic                arvalid,
    input  logic                arready,
    output logic [ADDR_W-1:0]   araddr,
    input  logic                rvalid,
    output logic                rready,
    // Load result context
    output logic                load_done,
    output lsu_pkg::funct3_t    req_funct3,
    output lsu_pkg::byte_off_t  req_offset,
    output lsu_pkg::reg_idx_t   req_rd
);

    import lsu_pkg::*;

    lsu_state_t        state;
    logic              accept;
    logic              aw_done;
    logic              w_done;
    logic [ADDR_W-1:0] addr_q;

    // Only IDLE raises ready, so this also implies IDLE
    assign accept = ready && en && (is_load || is_store);

    // A write channel is done once its valid has dropped or is handshaking
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    // R handshake of the current load
    assign load_done = (state == LOAD_DATA) && rvalid && rready;

    // Same address register serves both directions
    assign awaddr = addr_q;
    assign araddr = addr_q;

    //////////////////////////////////////////////////////////////////////
    // Request context
    //////////////////////////////////////////////////////////////////////

    // Captured on acceptance, stable for the whole access
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q     <= addr;
            wdata      <= store_data;
            wstrb      <= store_strb;
            req_funct3 <= funct3;
            req_offset <= addr[1:0];
            req_rd     <= rd;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= IDLE;
            ready   <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && is_store) begin
                        // Address and data go out together
                        ready   <= 1'b0;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= STORE_REQ;
                    end else if (accept) begin
                        // Read data accepted as soon as it shows up
                        ready   <= 1'b0;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= LOAD_REQ;
                    end else begin
                        // First edge after reset lands here too
                        ready <= 1'b1;
                    end
                end
                STORE_REQ: begin
                    // AW and W may be taken in either order
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= STORE_RESP;
                    end
                end
                STORE_RESP: begin
                    // Response code is not checked
                    if (bvalid) begin
                        bready <= 1'b0;
                        ready  <= 1'b1;
                        state  <= IDLE;
                    end
                end
                LOAD_REQ: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= LOAD_DATA;
                    end
                end
                LOAD_DATA: begin
                    // Register write happens in this same cycle
                    if (rvalid) begin
                        rready <= 1'b0;
                        ready  <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu_decode.sv */
// Instruction field decode, effective address computation,
// store data lane placement and write strobe generation
`default_nettype none

module lsu_decode #(
    parameter int ADDR_W = 32
) (
    input  lsu_pkg::word_t    instr,
    input  lsu_pkg::word_t    rs1_val,
    input  lsu_pkg::word_t    rs2_val,
    output lsu_pkg::reg_idx_t rs1_addr,
    output lsu_pkg::reg_idx_t rs2_addr,
    output lsu_pkg::reg_idx_t rd,
    output lsu_pkg::funct3_t  funct3,
    output logic              is_load,
    output logic              is_store,
    output logic [ADDR_W-1:0] addr,
    output lsu_pkg::word_t    store_data,
    output lsu_pkg::strb_t    store_strb
);

    import lsu_pkg::*;

    logic [6:0]  opcode;
    logic [11:0] imm12;
    word_t       imm_ext;
    word_t       sum;
    byte_off_t   offset;
    strb_t       base_strb;

    // Fixed instruction fields
    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign is_load  = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);

    //////////////////////////////////////////////////////////////////////
    // Effective address
    //////////////////////////////////////////////////////////////////////

    // S-type splits the immediate around the rd field
    assign imm12   = is_store ? {instr[31:25], instr[11:7]} : instr[31:20];
    assign imm_ext = {{20{imm12[11]}}, imm12};
    assign sum     = rs1_val + imm_ext;

    // Narrow buses keep only the low address bits
    assign addr    = sum[ADDR_W-1:0];
    assign offset  = sum[1:0];

    //////////////////////////////////////////////////////////////////////
    // Store lane placement
    //////////////////////////////////////////////////////////////////////

    // Rotate left so the low bytes of rs2 land at the offset
    always_comb begin
        case (offset)
            2'd1:    store_data = {rs2_val[23:0], rs2_val[31:24]};
            2'd2:    store_data = {rs2_val[15:0], rs2_val[31:16]};
            2'd3:    store_data = {rs2_val[7:0], rs2_val[31:8]};
            default: store_data = rs2_val;
        endcase
    end

    // One, two or four lanes depending on the access size
    always_comb begin
        case (funct3)
            F3_B:    base_strb = 4'b0001;
            F3_H:    base_strb = 4'b0011;
            default: base_strb = 4'b1111;
        endcase
    end

    // Aligned accesses only, so the shifted strobe never wraps
    assign store_strb = strb_t'(base_strb << offset);

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
// Load/store unit shared definitions
// Data-path types, RISC-V opcode and funct3 codes, controller states
`default_nettype none

package lsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data-path types
    //////////////////////////////////////////////////////////////////////

    // One register or AXI data word
    typedef logic [31:0] word_t;

    // Byte-lane write strobe, one bit per byte of word_t
    typedef logic [3:0] strb_t;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Access size and sign code from the instruction
    typedef logic [2:0] funct3_t;

    // Byte position inside a word
    typedef logic [1:0] byte_off_t;

    //////////////////////////////////////////////////////////////////////
    // RISC-V encodings
    //////////////////////////////////////////////////////////////////////

    // Major opcodes handled by the unit
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Size codes, shared by loads and stores
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    // Unsigned load variants
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    //////////////////////////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////////////////////////

    // Request sequencing, one access in flight
    typedef enum logic [2:0] {
        // Waiting for an issued instruction
        IDLE,
        // AW and W channels pending
        STORE_REQ,
        // Waiting for the write response
        STORE_RESP,
        // AR channel pending
        LOAD_REQ,
        // Waiting for read data
        LOAD_DATA
    } lsu_state_t;

endpackage

`default_nettype wire
